//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert
TOP       = lsu_lsc_ctl_tb
FILELIST  = list.f

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^Result: PASSED$$"

clean:
	rm -rf obj_dir

//--- list.f
+incdir+logic
logic/lsu_pkg.sv
logic/lsu_addr_gen.sv
logic/lsu_addr_check.sv
logic/lsu_pkt_pipe.sv
logic/lsu_ld_align.sv
logic/lsu_st_data_pipe.sv
logic/lsu_lsc_ctl.sv
test/lsu_lsc_ctl_tb.sv

//--- logic/lsu_addr_check.sv
// Region decode and access/misaligned fault detection for the dc1 address

`default_nettype none

`include "lsu_macros.svh"

module lsu_addr_check
   import lsu_pkg::*;
(
   input  logic [`LSU_DATA_W-1:0] addr_dc1,
   input  logic [`LSU_DATA_W-1:0] end_addr_dc1,
   input  lsu_pkt_t               pkt_dc1,
   output logic                   addr_in_dccm_dc1,
   output logic                   addr_in_pic_dc1,
   output logic                   access_fault_dc1,
   output logic                   misaligned_fault_dc1
);

   logic end_in_dccm_dc1;
   logic end_in_pic_dc1;
   logic region_cross_dc1;
   logic pic_size_bad_dc1;
   logic unaligned_dc1;

   //****************************************
   // Region decode
   //****************************************

   // Unsigned distance from the base, wraps below the base to a large value
   assign addr_in_dccm_dc1 = (addr_dc1 - `LSU_DCCM_BASE) < `LSU_DCCM_SIZE;
   assign end_in_dccm_dc1  = (end_addr_dc1 - `LSU_DCCM_BASE) < `LSU_DCCM_SIZE;
   assign addr_in_pic_dc1  = (addr_dc1 - `LSU_PIC_BASE) < `LSU_PIC_SIZE;
   assign end_in_pic_dc1   = (end_addr_dc1 - `LSU_PIC_BASE) < `LSU_PIC_SIZE;

   //****************************************
   // Faults
   //****************************************

   // First and last byte must sit in the same region
   assign region_cross_dc1 = (addr_in_dccm_dc1 != end_in_dccm_dc1) |
                             (addr_in_pic_dc1 != end_in_pic_dc1);

   // PIC registers only take full words
   assign pic_size_bad_dc1 = addr_in_pic_dc1 & (pkt_dc1.size != size_word);

   assign unaligned_dc1 = ((pkt_dc1.size == size_half) & addr_dc1[0]) |
                          ((pkt_dc1.size == size_word) & (addr_dc1[1:0] != 2'b00));

   assign access_fault_dc1 = pkt_dc1.valid & (region_cross_dc1 | pic_size_bad_dc1);

   // DCCM handles unaligned accesses itself
   assign misaligned_fault_dc1 = pkt_dc1.valid & unaligned_dc1 & ~addr_in_dccm_dc1;

endmodule

`default_nettype wire

//--- logic/lsu_addr_gen.sv
// Address generation: dc1 base and offset registers, start and end address

`default_nettype none

`include "lsu_macros.svh"

module lsu_addr_gen
   import lsu_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst,
   input  logic [`LSU_DATA_W-1:0]   rs1,
   input  logic [`LSU_OFFSET_W-1:0] offset,
   input  lsu_pkt_t                 pkt_dc1,
   output logic [`LSU_DATA_W-1:0]   addr_dc1,
   output logic [`LSU_DATA_W-1:0]   end_addr_dc1
);

   logic [`LSU_DATA_W-1:0]   rs1_dc1;
   logic [`LSU_OFFSET_W-1:0] offset_dc1;
   logic [`LSU_DATA_W-1:0]   offset_ext_dc1;
   logic [`LSU_DATA_W-1:0]   size_off_dc1;

   // Operands captured on the strobe edge
   always_ff @(posedge clk) begin
      if (rst) begin
         rs1_dc1    <= '0;
         offset_dc1 <= '0;
      end else begin
         rs1_dc1    <= rs1;
         offset_dc1 <= offset;
      end
   end

   assign offset_ext_dc1 = {{(`LSU_DATA_W - `LSU_OFFSET_W){offset_dc1[`LSU_OFFSET_W-1]}},
                            offset_dc1};

   assign addr_dc1 = rs1_dc1 + offset_ext_dc1;

   // Last byte touched by the access
   always_comb begin
      case (pkt_dc1.size)
         size_half: size_off_dc1 = `LSU_DATA_W'(1);
         size_word: size_off_dc1 = `LSU_DATA_W'(3);
         default:   size_off_dc1 = '0;
      endcase
   end

   assign end_addr_dc1 = addr_dc1 + size_off_dc1;

endmodule

`default_nettype wire

//--- logic/lsu_ld_align.sv
// Load data source select and extension in dc3, registered result in dc4

`default_nettype none

`include "lsu_macros.svh"

module lsu_ld_align
   import lsu_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst,
   input  lsu_pkt_t               pkt_dc3,
   input  logic                   addr_external_dc3,
   input  logic [`LSU_DATA_W-1:0] ld_data_dc3,
   input  logic [`LSU_DATA_W-1:0] bus_read_data_dc3,
   output logic [`LSU_DATA_W-1:0] lsu_result_dc3,
   output logic [`LSU_DATA_W-1:0] lsu_result_dc4
);

   logic [`LSU_DATA_W-1:0] ld_datafn_dc3;

   // External loads return over the bus, the rest from DCCM or PIC
   assign ld_datafn_dc3 = addr_external_dc3 ? bus_read_data_dc3 : ld_data_dc3;

   always_comb begin
      case (pkt_dc3.size)
         size_byte: begin
            lsu_result_dc3 = {{(`LSU_DATA_W-8){~pkt_dc3.unsign & ld_datafn_dc3[7]}},
                              ld_datafn_dc3[7:0]};
         end
         size_half: begin
            lsu_result_dc3 = {{(`LSU_DATA_W-16){~pkt_dc3.unsign & ld_datafn_dc3[15]}},
                              ld_datafn_dc3[15:0]};
         end
         default: lsu_result_dc3 = ld_datafn_dc3;
      endcase
   end

   // Copy for writeback one stage later
   always_ff @(posedge clk) begin
      if (rst) begin
         lsu_result_dc4 <= '0;
      end else begin
         lsu_result_dc4 <= lsu_result_dc3;
      end
   end

endmodule

`default_nettype wire

//--- logic/lsu_lsc_ctl.sv
// Load/store control pipeline top level, dc1 through dc5

`default_nettype none

`include "lsu_macros.svh"

module lsu_lsc_ctl
   import lsu_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst,

   // New access, one-cycle strobe
   input  logic                     lsu_valid,
   input  lsu_op_e                  lsu_op,
   input  lsu_size_e                lsu_size,
   input  logic                     lsu_unsign,
   input  logic                     st_fwd,
   input  logic [`LSU_DATA_W-1:0]   rs1,
   input  logic [`LSU_DATA_W-1:0]   rs2,
   input  logic [`LSU_OFFSET_W-1:0] offset,

   input  logic                     flush_dc2_up,
   input  logic                     flush_dc3,
   input  logic                     flush_dc4,
   input  logic                     flush_dc5,

   // Returned load data
   input  logic [`LSU_DATA_W-1:0]   ld_data_dc3,
   input  logic [`LSU_DATA_W-1:0]   bus_read_data_dc3,
   input  logic                     bus_error_dc3,

   output logic [`LSU_DATA_W-1:0]   lsu_result_dc3,
   output logic [`LSU_DATA_W-1:0]   lsu_result_dc4,
   output logic                     exc_valid_dc3,
   output logic                     exc_type_dc3,
   output logic [`LSU_DATA_W-1:0]   exc_addr_dc3,
   output logic                     commit_dc5,
   output logic [`LSU_DATA_W-1:0]   addr_dc5,
   output logic [`LSU_DATA_W-1:0]   store_data_dc5,
   output logic                     is_store_dc5
);

   logic [`LSU_DATA_W-1:0] addr_dc1;
   logic [`LSU_DATA_W-1:0] end_addr_dc1;
   logic                   addr_in_dccm_dc1;
   logic                   addr_in_pic_dc1;
   logic                   access_fault_dc1;
   logic                   misaligned_fault_dc1;
   lsu_pkt_t               pkt_dc1;
   lsu_pkt_t               pkt_dc3;
   logic                   addr_external_dc3;

   //****************************************
   // dc1 address path
   //****************************************

   lsu_addr_gen lsu_addr_gen_inst (.*);

   lsu_addr_check lsu_addr_check_inst (.*);

   //****************************************
   // Control pipeline
   //****************************************

   lsu_pkt_pipe lsu_pkt_pipe_inst (.*);

   //****************************************
   // Load and store data
   //****************************************

   lsu_ld_align lsu_ld_align_inst (.*);

   lsu_st_data_pipe lsu_st_data_pipe_inst (.*);

endmodule

`default_nettype wire

//--- logic/lsu_macros.svh
// Address map, data width and offset width for the load/store pipeline

`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

//****************************************
// Datapath widths
//****************************************

// Data and address width
`define LSU_DATA_W 32

// Immediate offset from the decoder
`define LSU_OFFSET_W 12

//****************************************
// Memory map
//****************************************

// Tightly coupled data memory, 64 KiB
`define LSU_DCCM_BASE 32'hf004_0000
`define LSU_DCCM_SIZE 32'h0001_0000

// Interrupt controller registers, 32 KiB
`define LSU_PIC_BASE  32'hf00c_0000
`define LSU_PIC_SIZE  32'h0000_8000

// Anything outside both regions goes to the external bus

`endif

//--- logic/lsu_pkg.sv
// Access size and operation enums, load/store control packet

`default_nettype none

package lsu_pkg;

   //****************************************
   // Enums
   //****************************************

   // Access size, same encoding as funct3[1:0]
   typedef enum logic [1:0] {
      size_byte = 2'b00,
      size_half = 2'b01,
      size_word = 2'b10
   } lsu_size_e;

   typedef enum logic {
      op_load  = 1'b0,
      op_store = 1'b1
   } lsu_op_e;

   //****************************************
   // Control packet
   //****************************************

   // Travels with each access from dc1 to dc5
   typedef struct packed {
      logic      valid;
      lsu_op_e   op;
      lsu_size_e size;
      // Zero extension for byte and half loads
      logic      unsign;
      // Store data comes from the dc3 load result
      logic      st_fwd_c1;
   } lsu_pkt_t;

endpackage

`default_nettype wire

//--- logic/lsu_pkt_pipe.sv
// Packet, valid, address and fault pipeline dc1 to dc5, exception report and commit

`default_nettype none

`include "lsu_macros.svh"

module lsu_pkt_pipe
   import lsu_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   lsu_valid,
   input  lsu_op_e                lsu_op,
   input  lsu_size_e              lsu_size,
   input  logic                   lsu_unsign,
   input  logic                   st_fwd,
   input  logic                   flush_dc2_up,
   input  logic                   flush_dc3,
   input  logic                   flush_dc4,
   input  logic                   flush_dc5,
   input  logic [`LSU_DATA_W-1:0] addr_dc1,
   input  logic                   addr_in_dccm_dc1,
   input  logic                   addr_in_pic_dc1,
   input  logic                   access_fault_dc1,
   input  logic                   misaligned_fault_dc1,
   input  logic                   bus_error_dc3,
   output lsu_pkt_t               pkt_dc1,
   output lsu_pkt_t               pkt_dc3,
   output logic                   addr_external_dc3,
   output logic                   exc_valid_dc3,
   output logic                   exc_type_dc3,
   output logic [`LSU_DATA_W-1:0] exc_addr_dc3,
   output logic                   commit_dc5,
   output logic [`LSU_DATA_W-1:0] addr_dc5,
   output logic                   is_store_dc5
);

   lsu_pkt_t               pkt_dc1_in, pkt_dc2_in, pkt_dc3_in, pkt_dc4_in, pkt_dc5_in;
   lsu_pkt_t               pkt_dc2, pkt_dc4, pkt_dc5;
   logic [`LSU_DATA_W-1:0] addr_dc2, addr_dc3, addr_dc4;
   logic                   addr_external_dc1, addr_external_dc2;
   logic                   access_fault_dc2, access_fault_dc3;
   logic                   misaligned_fault_dc2, misaligned_fault_dc3;

   //****************************************
   // Packet and valid chain
   //****************************************

   always_comb begin
      pkt_dc1_in.valid     = lsu_valid & ~flush_dc2_up;
      pkt_dc1_in.op        = lsu_op;
      pkt_dc1_in.size      = lsu_size;
      pkt_dc1_in.unsign    = lsu_unsign;
      pkt_dc1_in.st_fwd_c1 = st_fwd;

      pkt_dc2_in = pkt_dc1;
      pkt_dc3_in = pkt_dc2;
      pkt_dc4_in = pkt_dc3;
      pkt_dc5_in = pkt_dc4;

      // Each stage drops its access on the flush that covers it
      pkt_dc2_in.valid = pkt_dc1.valid & ~flush_dc2_up;
      pkt_dc3_in.valid = pkt_dc2.valid & ~flush_dc2_up;
      pkt_dc4_in.valid = pkt_dc3.valid & ~flush_dc3;
      pkt_dc5_in.valid = pkt_dc4.valid & ~flush_dc4;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         pkt_dc1 <= '0;
         pkt_dc2 <= '0;
         pkt_dc3 <= '0;
         pkt_dc4 <= '0;
         pkt_dc5 <= '0;
      end else begin
         pkt_dc1 <= pkt_dc1_in;
         pkt_dc2 <= pkt_dc2_in;
         pkt_dc3 <= pkt_dc3_in;
         pkt_dc4 <= pkt_dc4_in;
         pkt_dc5 <= pkt_dc5_in;
      end
   end

   //****************************************
   // Address, region and fault flags
   //****************************************

   assign addr_external_dc1 = ~(addr_in_dccm_dc1 | addr_in_pic_dc1);

   always_ff @(posedge clk) begin
      addr_dc2             <= addr_dc1;
      addr_dc3             <= addr_dc2;
      addr_dc4             <= addr_dc3;
      addr_dc5             <= addr_dc4;
      addr_external_dc2    <= addr_external_dc1;
      addr_external_dc3    <= addr_external_dc2;
      access_fault_dc2     <= access_fault_dc1;
      access_fault_dc3     <= access_fault_dc2;
      misaligned_fault_dc2 <= misaligned_fault_dc1;
      misaligned_fault_dc3 <= misaligned_fault_dc2;
   end

   // Exception report, bus errors count as access faults
   assign exc_valid_dc3 = pkt_dc3.valid & ~flush_dc3 &
                          (access_fault_dc3 | misaligned_fault_dc3 | bus_error_dc3);
   assign exc_type_dc3  = ~misaligned_fault_dc3;
   assign exc_addr_dc3  = addr_dc3;

   assign commit_dc5   = pkt_dc5.valid & ~flush_dc5;
   assign is_store_dc5 = pkt_dc5.valid & (pkt_dc5.op == op_store);

endmodule

`default_nettype wire

//--- logic/lsu_st_data_pipe.sv
// Store data pipeline dc1 to dc5 with forwarding of the dc3 load result

`default_nettype none

`include "lsu_macros.svh"

module lsu_st_data_pipe
   import lsu_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst,
   input  logic [`LSU_DATA_W-1:0] rs2,
   input  lsu_pkt_t               pkt_dc1,
   input  logic [`LSU_DATA_W-1:0] lsu_result_dc3,
   output logic [`LSU_DATA_W-1:0] store_data_dc5
);

   logic [`LSU_DATA_W-1:0] store_data_dc1;
   logic [`LSU_DATA_W-1:0] store_data_dc2_in;
   logic [`LSU_DATA_W-1:0] store_data_dc2;
   logic [`LSU_DATA_W-1:0] store_data_dc3;
   logic [`LSU_DATA_W-1:0] store_data_dc4;

   // Load two stages ahead supplies the data of a dependent store
   assign store_data_dc2_in = pkt_dc1.st_fwd_c1 ? lsu_result_dc3 : store_data_dc1;

   //****************************************
   // Data stages
   //****************************************

   always_ff @(posedge clk) begin
      if (rst) begin
         store_data_dc1 <= '0;
         store_data_dc2 <= '0;
         store_data_dc3 <= '0;
         store_data_dc4 <= '0;
         store_data_dc5 <= '0;
      end else begin
         store_data_dc1 <= rs2;
         store_data_dc2 <= store_data_dc2_in;
         store_data_dc3 <= store_data_dc2;
         store_data_dc4 <= store_data_dc3;
         store_data_dc5 <= store_data_dc4;
      end
   end

endmodule

`default_nettype wire

//--- test/lsu_golden.txt
# Columns (hex): valid op size unsign fwd rs1 rs2 offset flush bus_err rdata mask r3 ev et ea cm a5 s5 is
# flush bits: 0 dc2_up 1 dc3 2 dc4 3 dc5; mask bits: 0 r3 1 ev 2 et 3 ea 4 cm 5 a5 6 s5 7 is
0 0 0 0 0 00000000 00000000 000 0 0 00000000 12 00000000 0 0 00000000 0 00000000 00000000 0
0 0 0 0 0 00000000 00000000 000 0 0 00000000 12 00000000 0 0 00000000 0 00000000 00000000 0
1 0 0 0 0 f0040000 00000000 010 0 0 00000000 12 00000000 0 0 00000000 0 00000000 00000000 0
1 0 0 1 0 f0040000 00000000 011 0 0 00000000 12 00000000 0 0 00000000 0 00000000 00000000 0
1 0 1 0 0 f0040000 00000000 020 0 0 00000000 12 00000000 0 0 00000000 0 00000000 00000000 0
1 0 1 1 0 f0040000 00000000 022 0 0 000000f5 13 fffffff5 0 0 00000000 0 00000000 00000000 0
1 0 2 0 0 f0040000 00000000 024 0 0 000000f5 13 000000f5 0 0 00000000 0 00000000 00000000 0
1 0 2 0 0 00001000 00000000 004 0 0 12348765 b3 ffff8765 0 0 00000000 1 f0040010 00000000 0
1 0 2 0 0 00002000 00000000 000 0 0 55558765 b3 00008765 0 0 00000000 1 f0040011 00000000 0
1 0 2 0 0 00003000 00000000 002 0 0 deadbeef b3 deadbeef 0 0 00000000 1 f0040020 00000000 0
1 0 1 0 0 f00c0000 00000000 004 0 0 0f0f0f0f b3 f0f0f0f0 0 0 00000000 1 f0040022 00000000 0
1 0 2 0 0 f004fffc 00000000 002 0 1 00000000 bf ffffffff 1 1 00002000 1 f0040024 00000000 0
1 1 2 0 0 f0040000 11223344 100 0 0 00000000 be 00000000 1 0 00003002 1 00001004 00000000 0
1 0 2 0 0 f0040000 00000000 104 0 0 00000000 be 00000000 1 1 f00c0004 1 00002000 00000000 0
0 0 0 0 0 00000000 00000000 000 0 0 00000000 be 00000000 1 1 f004fffe 1 00003002 00000000 0
1 1 2 0 1 f0040000 99999999 108 0 0 00000000 b2 00000000 0 0 00000000 1 f00c0004 00000000 0
0 0 0 0 0 00000000 00000000 000 0 0 cafef00d b3 cafef00d 0 0 00000000 1 f004fffe 00000000 0
1 1 2 0 0 f0040000 a0a0a0a0 200 0 0 00000000 f2 00000000 0 0 00000000 1 f0040100 11223344 1
1 1 2 0 0 f0040000 b0b0b0b0 204 0 0 00000000 b2 00000000 0 0 00000000 1 f0040104 00000000 0
1 1 2 0 0 f0040000 c0c0c0c0 208 0 0 00000000 12 00000000 0 0 00000000 0 00000000 00000000 0
1 1 2 0 0 f0040000 d0d0d0d0 20c 1 0 00000000 f2 00000000 0 0 00000000 1 f0040108 cafef00d 1
1 1 2 0 0 f0040000 e0e0e0e0 210 0 0 00000000 12 00000000 0 0 00000000 0 00000000 00000000 0
1 0 2 0 0 00003000 00000000 001 0 0 00000000 f2 00000000 0 0 00000000 1 f0040200 a0a0a0a0 1
1 1 2 0 0 f0040000 f0f0f0f0 214 0 0 00000000 12 00000000 0 0 00000000 0 00000000 00000000 0
1 1 2 0 0 f0040000 12121212 218 0 0 00000000 12 00000000 0 0 00000000 0 00000000 00000000 0
1 1 2 0 0 f0040000 34343434 21c 2 0 00000000 12 00000000 0 0 00000000 0 00000000 00000000 0
0 0 0 0 0 00000000 00000000 000 0 0 00000000 f2 00000000 0 0 00000000 1 f0040210 e0e0e0e0 1
0 0 0 0 0 00000000 00000000 000 4 0 00000000 12 00000000 0 0 00000000 0 00000000 00000000 0
0 0 0 0 0 00000000 00000000 000 0 0 00000000 12 00000000 0 0 00000000 0 00000000 00000000 0
0 0 0 0 0 00000000 00000000 000 8 0 00000000 12 00000000 0 0 00000000 0 00000000 00000000 0
0 0 0 0 0 00000000 00000000 000 0 0 00000000 f2 00000000 0 0 00000000 1 f004021c 34343434 1
0 0 0 0 0 00000000 00000000 000 0 0 00000000 12 00000000 0 0 00000000 0 00000000 00000000 0

//--- test/lsu_lsc_ctl_tb.sv
// Testbench for the load/store control pipeline: clock, reset, golden replay, checks, report

`default_nettype none

`include "lsu_macros.svh"

module lsu_lsc_ctl_tb
   import lsu_pkg::*;
();

   localparam int    MAX_LINES    = 64;
   localparam int    RESET_CYCLES = 4;
   localparam string GOLDEN_FILE  = "test/lsu_golden.txt";

   logic                     clk;
   logic                     rst;
   logic                     lsu_valid;
   lsu_op_e                  lsu_op;
   lsu_size_e                lsu_size;
   logic                     lsu_unsign;
   logic                     st_fwd;
   logic [`LSU_DATA_W-1:0]   rs1;
   logic [`LSU_DATA_W-1:0]   rs2;
   logic [`LSU_OFFSET_W-1:0] offset;
   logic                     flush_dc2_up;
   logic                     flush_dc3;
   logic                     flush_dc4;
   logic                     flush_dc5;
   logic [`LSU_DATA_W-1:0]   ld_data_dc3;
   logic [`LSU_DATA_W-1:0]   bus_read_data_dc3;
   logic                     bus_error_dc3;
   logic [`LSU_DATA_W-1:0]   lsu_result_dc3;
   logic [`LSU_DATA_W-1:0]   lsu_result_dc4;
   logic                     exc_valid_dc3;
   logic                     exc_type_dc3;
   logic [`LSU_DATA_W-1:0]   exc_addr_dc3;
   logic                     commit_dc5;
   logic [`LSU_DATA_W-1:0]   addr_dc5;
   logic [`LSU_DATA_W-1:0]   store_data_dc5;
   logic                     is_store_dc5;

   // Golden columns, one entry per cycle
   logic [31:0] g_valid[0:MAX_LINES-1], g_op[0:MAX_LINES-1], g_size[0:MAX_LINES-1];
   logic [31:0] g_unsign[0:MAX_LINES-1], g_fwd[0:MAX_LINES-1], g_rs1[0:MAX_LINES-1];
   logic [31:0] g_rs2[0:MAX_LINES-1], g_offset[0:MAX_LINES-1], g_flush[0:MAX_LINES-1];
   logic [31:0] g_berr[0:MAX_LINES-1], g_rdata[0:MAX_LINES-1], g_mask[0:MAX_LINES-1];
   logic [31:0] g_r3[0:MAX_LINES-1], g_ev[0:MAX_LINES-1], g_et[0:MAX_LINES-1];
   logic [31:0] g_ea[0:MAX_LINES-1], g_cm[0:MAX_LINES-1], g_a5[0:MAX_LINES-1];
   logic [31:0] g_s5[0:MAX_LINES-1], g_is[0:MAX_LINES-1];

   int num_lines      = 0;
   int mismatch_count = 0;
   int other_count    = 0;
   int cycle_count    = 0;
   int cycle_limit    = 0;

   lsu_lsc_ctl lsu_lsc_ctl_inst (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Ends a hung run once the replay has had time to finish
   always @(posedge clk) begin
      cycle_count++;
      if (cycle_limit > 0 && cycle_count > cycle_limit) begin
         $display("Timeout: replay did not finish within %0d cycles", cycle_limit);
         $display("Result: FAILED");
         $finish;
      end
   end

   //****************************************
   // Golden file
   //****************************************

   task automatic load_golden();
      int    fd;
      int    code;
      string text;
      byte   first;
      fd = $fopen(GOLDEN_FILE, "r");
      if (fd == 0) begin
         $display("Could not open the golden file %s", GOLDEN_FILE);
         other_count++;
         return;
      end
      while (!$feof(fd) && num_lines < MAX_LINES) begin
         code = $fgets(text, fd);
         if (code == 0 || text.len() < 2) continue;
         first = text[0];
         // Column description lines
         if (first == "#") continue;
         code = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        g_valid[num_lines], g_op[num_lines], g_size[num_lines],
                        g_unsign[num_lines], g_fwd[num_lines], g_rs1[num_lines],
                        g_rs2[num_lines], g_offset[num_lines], g_flush[num_lines],
                        g_berr[num_lines], g_rdata[num_lines], g_mask[num_lines],
                        g_r3[num_lines], g_ev[num_lines], g_et[num_lines], g_ea[num_lines],
                        g_cm[num_lines], g_a5[num_lines], g_s5[num_lines], g_is[num_lines]);
         if (code != 20) begin
            $display("Golden line could not be read: %s", text);
            other_count++;
         end else begin
            num_lines++;
         end
      end
      $fclose(fd);
      if (num_lines == 0) begin
         $display("The golden file holds no stimulus lines");
         other_count++;
      end
   endtask

   //****************************************
   // Drive and check
   //****************************************

   task automatic drive_line(input int i);
      lsu_valid         = g_valid[i][0];
      lsu_op            = lsu_op_e'(g_op[i][0]);
      lsu_size          = lsu_size_e'(g_size[i][1:0]);
      lsu_unsign        = g_unsign[i][0];
      st_fwd            = g_fwd[i][0];
      rs1               = g_rs1[i];
      rs2               = g_rs2[i];
      offset            = g_offset[i][`LSU_OFFSET_W-1:0];
      flush_dc2_up      = g_flush[i][0];
      flush_dc3         = g_flush[i][1];
      flush_dc4         = g_flush[i][2];
      flush_dc5         = g_flush[i][3];
      bus_error_dc3     = g_berr[i][0];
      // Bus data is the inverse so the source select shows in the result
      ld_data_dc3       = g_rdata[i];
      bus_read_data_dc3 = ~g_rdata[i];
   endtask

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      assert (act === exp) else begin
         $display("Mismatch %s: expected %h, actual %h", name, exp, act);
         mismatch_count++;
      end
   endtask

   task automatic check_line(input int i);
      string tag;
      tag = $sformatf("line %0d", i);
      if (g_mask[i][0]) check_value({tag, " lsu_result_dc3"}, g_r3[i], lsu_result_dc3);
      // dc4 holds the dc3 result of the cycle before
      if (i > 0 && g_mask[i-1][0]) begin
         check_value({tag, " lsu_result_dc4"}, g_r3[i-1], lsu_result_dc4);
      end
      if (g_mask[i][1]) check_value({tag, " exc_valid_dc3"}, g_ev[i], 32'(exc_valid_dc3));
      if (g_mask[i][2]) check_value({tag, " exc_type_dc3"}, g_et[i], 32'(exc_type_dc3));
      if (g_mask[i][3]) check_value({tag, " exc_addr_dc3"}, g_ea[i], exc_addr_dc3);
      if (g_mask[i][4]) check_value({tag, " commit_dc5"}, g_cm[i], 32'(commit_dc5));
      if (g_mask[i][5]) check_value({tag, " addr_dc5"}, g_a5[i], addr_dc5);
      if (g_mask[i][6]) check_value({tag, " store_data_dc5"}, g_s5[i], store_data_dc5);
      if (g_mask[i][7]) check_value({tag, " is_store_dc5"}, g_is[i], 32'(is_store_dc5));
   endtask

   task automatic report_and_finish();
      $display("Checks done: %0d mismatches, %0d other errors", mismatch_count, other_count);
      if (mismatch_count == 0 && other_count == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   endtask

   //****************************************
   // Main sequence
   //****************************************

   initial begin
      rst               = 1'b1;
      lsu_valid         = 1'b0;
      lsu_op            = op_load;
      lsu_size          = size_byte;
      lsu_unsign        = 1'b0;
      st_fwd            = 1'b0;
      rs1               = '0;
      rs2               = '0;
      offset            = '0;
      flush_dc2_up      = 1'b0;
      flush_dc3         = 1'b0;
      flush_dc4         = 1'b0;
      flush_dc5         = 1'b0;
      ld_data_dc3       = '0;
      bus_read_data_dc3 = '0;
      bus_error_dc3     = 1'b0;
      load_golden();
      cycle_limit = num_lines + RESET_CYCLES + 20;
      repeat (RESET_CYCLES) @(negedge clk);
      rst = 1'b0;
      for (int i = 0; i < num_lines; i++) begin
         drive_line(i);
         #4;
         check_line(i);
         @(negedge clk);
      end
      report_and_finish();
   end

endmodule

`default_nettype wire
